/* aluShift.sv */
// Rm shifter, operand A zeroing, ALU for ADD/CMP/AND/MVN and MOV pass, zero/negative/overflow flags
`default_nettype none
`timescale 1ns/1ps

module aluShift import cpuPkg::*; (
    input  wire word_t    a,
    input  wire word_t    b,
    input  wire logic     asel,
    input  wire shiftOp_t shift,
    input  wire aluOp_t   aluOp,
    input  wire opClass_t opClass,
    output word_t         out,
    output status_t       flags
);

    word_t shifted;
    word_t ain;
    word_t sum;
    word_t diff;
    logic  addOvf;
    logic  subOvf;

    always_comb begin
        case (shift)
            shLsl1:  shifted = {b[wordWidth-2:0], 1'b0};
            shLsr1:  shifted = {1'b0, b[wordWidth-1:1]};
            shAsr1:  shifted = {b[wordWidth-1], b[wordWidth-1:1]};
            default: shifted = b;
        endcase
    end

    assign ain  = asel ? '0 : a;
    assign sum  = ain + shifted;
    assign diff = ain - shifted;

    // signed overflow from the sign bits
    assign addOvf = (ain[wordWidth-1] == shifted[wordWidth-1]) &&
                    (sum[wordWidth-1] != ain[wordWidth-1]);
    assign subOvf = (ain[wordWidth-1] != shifted[wordWidth-1]) &&
                    (diff[wordWidth-1] != ain[wordWidth-1]);

    always_comb begin
        flags.v = 1'b0;
        if (opClass == opMov) begin
            out = sum;   // MOV Rd, Rm as zeroed A plus shifted Rm
        end else begin
            case (aluOp)
                aluAdd: begin
                    out     = sum;
                    flags.v = addOvf;
                end
                aluCmp: begin
                    out     = diff;
                    flags.v = subOvf;
                end
                aluAnd:  out = ain & shifted;
                default: out = ~shifted;   // MVN
            endcase
        end
        flags.z = (out == '0);
        flags.n = out[wordWidth-1];
    end

endmodule

`default_nettype wire

/* cpuController.sv */
// req/ack handshake and multicycle sequencing FSM driving the datapath control struct
`default_nettype none
`timescale 1ns/1ps

module cpuController import cpuPkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     req,
    input  wire decoded_t decoded,
    output logic          ack,
    output logic          loadIr,
    output ctrl_t         ctrl
);

    typedef enum logic [3:0] {
        idle,
        decode,
        getImm,
        loadA,
        loadB,
        execute,
        writeBack,
        loadS,
        done
    } ctrlState_t;

    ctrlState_t state;
    ctrlState_t nextState;
    logic       zeroA;

    // MOV Rd, Rm and MVN ignore Rn
    assign zeroA = (decoded.opClass == opMov) || (decoded.aluOp == aluMvn);

    assign loadIr = (state == idle) && req;   // instruction captured on accept

    always_comb begin
        nextState = state;
        case (state)
            idle: if (req) nextState = decode;
            decode: begin
                case (decoded.opClass)
                    opMov: begin
                        if (decoded.aluOp == movImm) begin
                            nextState = getImm;
                        end else if (decoded.aluOp == movReg) begin
                            nextState = loadB;
                        end else begin
                            nextState = done;   // unused MOV form, no effect
                        end
                    end
                    opAlu:   nextState = (decoded.aluOp == aluMvn) ? loadB : loadA;
                    default: nextState = done;   // illegal opcode
                endcase
            end
            getImm: nextState = done;
            loadA:  nextState = loadB;
            loadB: begin
                if (decoded.opClass == opAlu && decoded.aluOp == aluCmp) begin
                    nextState = loadS;   // CMP writes no register
                end else begin
                    nextState = execute;
                end
            end
            execute:   nextState = writeBack;
            writeBack: nextState = done;
            loadS:     nextState = done;
            done:      if (!req) nextState = idle;
            default:   nextState = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            ack   <= 1'b0;
        end else begin
            state <= nextState;
            ack   <= (nextState == done);
        end
    end

    // per-state datapath controls
    always_comb begin
        ctrl = '0;
        case (state)
            getImm: begin
                ctrl.nsel  = selRn;
                ctrl.vsel  = srcImm;
                ctrl.write = 1'b1;
            end
            loadA: begin
                ctrl.nsel  = selRn;
                ctrl.loadA = 1'b1;
            end
            loadB: begin
                ctrl.nsel  = selRm;
                ctrl.loadB = 1'b1;
            end
            execute: begin
                ctrl.loadC = 1'b1;
                ctrl.asel  = zeroA;
            end
            writeBack: begin
                ctrl.nsel  = selRd;
                ctrl.vsel  = srcC;
                ctrl.write = 1'b1;
            end
            loadS: ctrl.loadS = 1'b1;
            default: ;
        endcase
    end

    // ack only answers a request that is still held
    ackOnlyForReq: assert property (
        @(posedge clk) disable iff (reset)
        $rose(ack) |-> req
    ) else $error("ack rose without a pending request");

    // sequencing relies on the decoded fields staying put
    decodeHeldWhileBusy: assert property (
        @(posedge clk) disable iff (reset)
        !loadIr |=> $stable(decoded)
    ) else $error("decoded instruction changed without loadIr");

endmodule

`default_nettype wire

/* cpuPkg.sv */
// shared widths, instruction field positions, opcode enums, decode, control and status structs
`default_nettype none

package cpuPkg;

    localparam int wordWidth = 16;
    localparam int numRegs   = 8;

    // instruction field positions
    localparam int opHi     = 15;
    localparam int opLo     = 13;
    localparam int aluHi    = 12;
    localparam int aluLo    = 11;
    localparam int rnHi     = 10;
    localparam int rnLo     = 8;
    localparam int rdHi     = 7;
    localparam int rdLo     = 5;
    localparam int shHi     = 4;
    localparam int shLo     = 3;
    localparam int rmHi     = 2;
    localparam int rmLo     = 0;
    localparam int immWidth = 8;

    typedef logic [wordWidth-1:0]        word_t;
    typedef logic [$clog2(numRegs)-1:0] regAddr_t;

    typedef enum logic [2:0] {
        opMov     = 3'b110,
        opAlu     = 3'b101,
        opIllegal = 3'b000
    } opClass_t;

    typedef enum logic [1:0] {
        aluAdd = 2'b00,
        aluCmp = 2'b01,
        aluAnd = 2'b10,
        aluMvn = 2'b11
    } aluOp_t;

    // MOV reuses the alu field to pick its form
    localparam aluOp_t movImm = aluAnd;
    localparam aluOp_t movReg = aluAdd;

    typedef enum logic [1:0] {
        shNone = 2'b00,
        shLsl1 = 2'b01,
        shLsr1 = 2'b10,  // zero fill
        shAsr1 = 2'b11
    } shiftOp_t;

    typedef struct packed {
        opClass_t opClass;
        aluOp_t   aluOp;
        regAddr_t rn;
        regAddr_t rd;
        regAddr_t rm;
        shiftOp_t shift;
        word_t    sximm8;
    } decoded_t;

    typedef enum logic [1:0] {selRn, selRd, selRm} regSel_t;

    typedef enum logic {srcImm, srcC} writeSrc_t;

    typedef struct packed {
        regSel_t   nsel;
        writeSrc_t vsel;
        logic      write;
        logic      loadA;
        logic      loadB;
        logic      loadC;
        logic      loadS;
        logic      asel;   // zero operand A
    } ctrl_t;

    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } status_t;

endpackage

`default_nettype wire

/* datapath.sv */
// register number and write-back muxes, A/B/C and status registers around regFile and aluShift
`default_nettype none
`timescale 1ns/1ps

module datapath import cpuPkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire ctrl_t    ctrl,
    input  wire decoded_t decoded,
    output word_t         result,
    output status_t       status
);

    regAddr_t regNum;
    word_t    writeData;
    word_t    readData;
    word_t    regA;
    word_t    regB;
    word_t    aluOut;
    status_t  aluFlags;

    // one register number serves both ports
    always_comb begin
        case (ctrl.nsel)
            selRn:   regNum = decoded.rn;
            selRd:   regNum = decoded.rd;
            default: regNum = decoded.rm;
        endcase
    end

    assign writeData = (ctrl.vsel == srcC) ? result : decoded.sximm8;

    regFile regFile_i (
        .clk       (clk),
        .reset     (reset),
        .write     (ctrl.write),
        .writeNum  (regNum),
        .writeData (writeData),
        .readNum   (regNum),
        .readData  (readData)
    );

    // operand registers
    always_ff @(posedge clk) begin
        if (ctrl.loadA) begin
            regA <= readData;
        end
        if (ctrl.loadB) begin
            regB <= readData;
        end
    end

    aluShift aluShift_i (
        .a       (regA),
        .b       (regB),
        .asel    (ctrl.asel),
        .shift   (decoded.shift),
        .aluOp   (decoded.aluOp),
        .opClass (decoded.opClass),
        .out     (aluOut),
        .flags   (aluFlags)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            status <= '0;
        end else begin
            if (ctrl.loadC) begin
                result <= aluOut;   // C register
            end
            if (ctrl.loadS) begin
                status <= aluFlags;   // only CMP gets here
            end
        end
    end

endmodule

`default_nettype wire

/* instrDecoder.sv */
// instruction register with field split, opcode classing and immediate sign extension
`default_nettype none
`timescale 1ns/1ps

module instrDecoder import cpuPkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     loadIr,
    input  wire word_t    instr,
    output decoded_t      decoded
);

    word_t ir;

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;   // decodes as illegal
        end else if (loadIr) begin
            ir <= instr;
        end
    end

    always_comb begin
        case (ir[opHi:opLo])
            3'b110:  decoded.opClass = opMov;
            3'b101:  decoded.opClass = opAlu;
            default: decoded.opClass = opIllegal;
        endcase

        decoded.aluOp = aluOp_t'(ir[aluHi:aluLo]);
        decoded.rn    = ir[rnHi:rnLo];
        decoded.rd    = ir[rdHi:rdLo];
        decoded.rm    = ir[rmHi:rmLo];
        decoded.shift = shiftOp_t'(ir[shHi:shLo]);

        // replicate bit 7 up to the word width
        decoded.sximm8 = {{(wordWidth-immWidth){ir[immWidth-1]}}, ir[immWidth-1:0]};
    end

endmodule

`default_nettype wire

/* regFile.sv */
// eight-entry register file, one synchronous write port and one combinational read port
`default_nettype none
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     write,
    input  wire regAddr_t writeNum,
    input  wire word_t    writeData,
    input  wire regAddr_t readNum,
    output word_t         readData
);

    word_t regs [numRegs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (write) begin
            regs[writeNum] <= writeData;
        end
    end

    assign readData = regs[readNum];   // no read latency

    // the controller must settle nsel before it raises write
    writeNumKnown: assert property (
        @(posedge clk) disable iff (reset)
        write |-> !$isunknown(writeNum)
    ) else $error("regFile write with unknown register number");

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the simpleCpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module simpleCpuTb -o simpleCpuTb

output=$(./obj_dir/simpleCpuTb)
echo "$output"

if grep -q "Verification passed" <<< "$output"; then
    exit 0
fi
exit 1

/* simpleCpu.sv */
// top level wiring of instruction decoder, sequencing controller and datapath
`default_nettype none
`timescale 1ns/1ps

module simpleCpu import cpuPkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  req,
    input  wire word_t instr,
    output logic       ack,
    output word_t      result,
    output status_t    status
);

    logic     loadIr;
    decoded_t decoded;
    ctrl_t    ctrl;

    instrDecoder instrDecoder_i (
        .clk     (clk),
        .reset   (reset),
        .loadIr  (loadIr),
        .instr   (instr),
        .decoded (decoded)
    );

    cpuController cpuController_i (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .decoded (decoded),
        .ack     (ack),
        .loadIr  (loadIr),
        .ctrl    (ctrl)
    );

    datapath datapath_i (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .decoded (decoded),
        .result  (result),
        .status  (status)
    );

endmodule

`default_nettype wire

/* simpleCpuTb.sv */
// testbench for simpleCpu: clock, reset, random instruction stimulus, reference model, compare tasks
`default_nettype none
`timescale 1ns/1ps

module simpleCpuTb import cpuPkg::*; ();

    localparam int maxInstr       = 400;
    localparam int cyclesPerInstr = 20;
    localparam int cycleLimit     = maxInstr * cyclesPerInstr;   // whole run budget
    localparam int ackLimit       = 20;   // per handshake phase

    logic    clk;
    logic    reset;
    logic    req;
    word_t   instr;
    logic    ack;
    word_t   result;
    status_t status;

    word_t   modelRegs [8];
    word_t   modelResult;
    status_t modelStatus;
    logic    expCheckRes;
    event    checkEv;

    int cycles;
    int valueErrs;
    int hsErrs;
    logic ackSeen;

    simpleCpu simpleCpu_i (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .instr  (instr),
        .ack    (ack),
        .result (result),
        .status (status)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic word_t movImmInstr(regAddr_t rn, logic [7:0] imm8);
        return {3'b110, 2'b10, rn, imm8};
    endfunction

    function automatic word_t movRegInstr(regAddr_t rd, regAddr_t rm, shiftOp_t sh);
        return {3'b110, 2'b00, 3'b000, rd, sh, rm};
    endfunction

    function automatic word_t aluInstr(aluOp_t op, regAddr_t rn, regAddr_t rd, regAddr_t rm,
                                       shiftOp_t sh);
        return {3'b101, op, rn, rd, sh, rm};
    endfunction

    function automatic regAddr_t randReg();
        return regAddr_t'($urandom_range(0, 7));
    endfunction

    function automatic shiftOp_t randShift();
        return shiftOp_t'($urandom_range(0, 3));
    endfunction

    // Rm shift rules: none, lsl1, lsr1 zero fill, asr1
    function automatic word_t shiftRef(word_t v, logic [1:0] sh);
        case (sh)
            2'b01:   return v << 1;
            2'b10:   return v >> 1;
            2'b11:   return word_t'($signed(v) >>> 1);
            default: return v;
        endcase
    endfunction

    // steps the model by one instruction, returns whether result is to be checked
    function automatic logic stepModel(word_t ins);
        logic [2:0] rn;
        logic [2:0] rd;
        logic [2:0] rm;
        word_t      rnVal;
        word_t      sb;
        word_t      diff;
        int         sd;
        logic       checkRes;
        rn       = ins[10:8];
        rd       = ins[7:5];
        rm       = ins[2:0];
        rnVal    = modelRegs[rn];
        sb       = shiftRef(modelRegs[rm], ins[4:3]);
        checkRes = 1'b1;
        if (ins[15:13] == 3'b110 && ins[12:11] == 2'b10) begin
            modelRegs[rn] = {{8{ins[7]}}, ins[7:0]};   // C untouched
            checkRes = 1'b0;
        end else if (ins[15:13] == 3'b110 && ins[12:11] == 2'b00) begin
            modelResult   = sb;
            modelRegs[rd] = sb;
        end else if (ins[15:13] == 3'b101) begin
            case (ins[12:11])
                2'b00: begin
                    modelResult   = rnVal + sb;
                    modelRegs[rd] = modelResult;
                end
                2'b01: begin
                    diff = rnVal - sb;
                    sd   = int'($signed(rnVal)) - int'($signed(sb));
                    modelStatus.z = (diff == 16'h0000);
                    modelStatus.n = diff[15];
                    modelStatus.v = (sd > 32767) || (sd < -32768);
                end
                2'b10: begin
                    modelResult   = rnVal & sb;
                    modelRegs[rd] = modelResult;
                end
                default: begin
                    modelResult   = ~sb;
                    modelRegs[rd] = modelResult;
                end
            endcase
        end
        return checkRes;   // other MOV forms and illegal opcodes change nothing
    endfunction

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, expected, actual);
            valueErrs++;
        end
    endtask

    task automatic checkFlags(input string name, input status_t expected,
                              input status_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, expected, actual);
            valueErrs++;
        end
    endtask

    // full four-phase handshake for one instruction
    task automatic runInstr(input word_t ins);
        int waitCycles;
        @(posedge clk);
        #2;
        instr = ins;
        req   = 1'b1;
        waitCycles = 0;
        do begin
            @(negedge clk);
            waitCycles++;
        end while (!ack && waitCycles < ackLimit);
        if (!ack) begin
            $display("no ack for instruction 0x%h after %0d cycles", ins, waitCycles);
            hsErrs++;
        end
        @(posedge clk);
        #2;
        req = 1'b0;
        waitCycles = 0;
        do begin
            @(negedge clk);
            waitCycles++;
        end while (ack && waitCycles < ackLimit);
        if (waitCycles != 2) begin
            $display("ack did not fall in the cycle after req fell for instruction 0x%h", ins);
            hsErrs++;
        end
        expCheckRes = stepModel(ins);
        -> checkEv;
    endtask

    task automatic readBackRegs();
        for (int r = 0; r < 8; r++) begin
            runInstr(movRegInstr(regAddr_t'(r), regAddr_t'(r), shNone));
        end
    endtask

    always @(checkEv) begin
        if (expCheckRes) begin
            checkWord("result", modelResult, result);
        end
        checkFlags("status", modelStatus, status);
    end

    // ack may only rise while req is held high
    always @(negedge clk) begin
        if (!reset && ack && !ackSeen && !req) begin
            $display("ack rose while req was low");
            hsErrs++;
        end
        ackSeen = ack;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("timeout, run still busy after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        logic [2:0] op;
        aluOp_t     aop;
        void'($urandom(32'he9fdc799));
        reset   = 1'b1;
        req     = 1'b0;
        instr   = '0;
        cycles  = 0;
        valueErrs = 0;
        hsErrs  = 0;
        ackSeen = 1'b0;
        modelResult = '0;
        modelStatus = '0;
        for (int r = 0; r < 8; r++) begin
            modelRegs[r] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        // immediates, positive then negative, read back
        for (int r = 0; r < 8; r++) begin
            runInstr(movImmInstr(regAddr_t'(r), {1'b0, 7'($urandom)}));
            runInstr(movRegInstr(regAddr_t'(r), regAddr_t'(r), shNone));
            runInstr(movImmInstr(regAddr_t'(r), {1'b1, 7'($urandom)}));
            runInstr(movRegInstr(regAddr_t'(r), regAddr_t'(r), shNone));
        end

        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 6; k++) begin
                runInstr(movRegInstr(randReg(), randReg(), shiftOp_t'(s)));
            end
        end

        for (int k = 0; k < 60; k++) begin
            case ($urandom_range(0, 2))
                0:       aop = aluAdd;
                1:       aop = aluAnd;
                default: aop = aluMvn;
            endcase
            runInstr(aluInstr(aop, randReg(), randReg(), randReg(), randShift()));
        end

        // r0 = 0x8000, r1 = 1, r2 = 0x007f for overflow and equal cases
        runInstr(movImmInstr(3'd0, 8'h80));
        for (int k = 0; k < 8; k++) begin
            runInstr(movRegInstr(3'd0, 3'd0, shLsl1));
        end
        runInstr(movImmInstr(3'd1, 8'h01));
        runInstr(movImmInstr(3'd2, 8'h7f));
        runInstr(aluInstr(aluCmp, 3'd0, 3'd5, 3'd1, shNone));
        runInstr(aluInstr(aluCmp, 3'd2, 3'd5, 3'd0, shNone));
        runInstr(aluInstr(aluCmp, 3'd1, 3'd5, 3'd1, shNone));
        runInstr(aluInstr(aluCmp, 3'd0, 3'd5, 3'd0, shNone));
        runInstr(aluInstr(aluCmp, 3'd2, 3'd5, 3'd1, shLsl1));
        runInstr(aluInstr(aluCmp, 3'd1, 3'd5, 3'd2, shNone));
        runInstr(aluInstr(aluCmp, 3'd0, 3'd5, 3'd1, shAsr1));
        for (int k = 0; k < 40; k++) begin
            runInstr(aluInstr(aluCmp, randReg(), randReg(), randReg(), randShift()));
        end
        readBackRegs();

        for (int k = 0; k < 20; k++) begin
            do begin
                op = 3'($urandom_range(0, 7));
            end while (op == 3'b110 || op == 3'b101);
            runInstr({op, 13'($urandom)});
        end
        // unused MOV forms
        for (int k = 0; k < 6; k++) begin
            runInstr({3'b110, 1'($urandom), 1'b1, 11'($urandom)});
        end
        readBackRegs();

        for (int k = 0; k < 100; k++) begin
            runInstr(word_t'($urandom));
        end
        readBackRegs();

        repeat (2) @(posedge clk);
        $display("errors: %0d value, %0d handshake", valueErrs, hsErrs);
        if (valueErrs == 0 && hsErrs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
cpuPkg.sv
instrDecoder.sv
regFile.sv
aluShift.sv
datapath.sv
cpuController.sv
simpleCpu.sv
simpleCpuTb.sv
